// File: cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

  // byte address width of the core
  localparam int ADDR_WIDTH = 32;

  // set associativity
  localparam int WAYS = 4;
  localparam int WAY_WIDTH = $clog2(WAYS);

  // sets per way
  localparam int SETS = 64;
  localparam int INDEX_WIDTH = $clog2(SETS);

  // line of 8 words, 4 bytes each
  localparam int WORD_BYTES = 4;
  localparam int LINE_WORDS = 8;
  localparam int BLOCK_OFFSET_WIDTH = $clog2(LINE_WORDS * WORD_BYTES);

  // whatever is left above index and offset
  localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - BLOCK_OFFSET_WIDTH;

  // field view of a byte address, msb first
  typedef struct packed {
    logic [TAG_WIDTH-1:0]          tag;
    logic [INDEX_WIDTH-1:0]        index;
    logic [BLOCK_OFFSET_WIDTH-1:0] offset;
  } cache_addr_fields_s;

  // same 32 bits, raw word or tag/index/offset
  typedef union packed {
    logic [ADDR_WIDTH-1:0] raw;
    cache_addr_fields_s    fields;
  } cache_addr_u;

endpackage

`default_nettype wire

// File: mhu_pkg.sv
`default_nettype none

package mhu_pkg;

  localparam int STATE_WIDTH = 3;
  localparam int CMD_WIDTH = 2;

  // miss handler states
  typedef enum logic [STATE_WIDTH-1:0] {
    START            = 3'd0,
    SEND_REFILL_ADDR = 3'd1,
    STORE_TAG_MISS   = 3'd2,
    WAIT_SNOOP_DONE  = 3'd3,
    SEND_EVICT_ADDR  = 3'd4,
    SEND_EVICT_DATA  = 3'd5,
    WRITE_FILL_DATA  = 3'd6
  } mhu_state_e;

  // address command, travels as the wishbone address tag
  typedef enum logic [CMD_WIDTH-1:0] {
    NOP         = 2'd0,
    REFILL_ADDR = 2'd1,
    EVICT_ADDR  = 2'd2
  } dma_cmd_e;

  // presented by the tag-verify stage at capture
  typedef struct packed {
    cache_geom_pkg::cache_addr_u                              addr;
    logic                                                     store_tag_miss;
    logic                                                     track_miss;
    logic [cache_geom_pkg::WAY_WIDTH-1:0]                     hit_way;
    logic [cache_geom_pkg::WAY_WIDTH-1:0]                     chosen_way;
    logic [cache_geom_pkg::WAYS-1:0][cache_geom_pkg::TAG_WIDTH-1:0] tags;
    logic [cache_geom_pkg::WAYS-1:0]                          valid;
    logic [cache_geom_pkg::WAYS-1:0]                          dirty;
  } miss_info_s;

  // context held for the life of one miss
  typedef struct packed {
    logic [cache_geom_pkg::TAG_WIDTH-1:0]   tag;
    logic [cache_geom_pkg::INDEX_WIDTH-1:0] index;
    logic [cache_geom_pkg::WAY_WIDTH-1:0]   way;
    logic [cache_geom_pkg::TAG_WIDTH-1:0]   victim_tag;
    logic                                   victim_needs_evict;
    logic                                   track_miss;
    logic                                   store_tag_miss;
  } miss_ctx_s;

  // wishbone classic master side, address phase only
  typedef struct packed {
    logic                                  cyc;
    logic                                  stb;
    logic                                  we;
    logic [cache_geom_pkg::ADDR_WIDTH-1:0] adr;
    dma_cmd_e                              cmd;
  } dma_req_s;

  typedef struct packed {
    logic evict_v;
    logic store_tag_miss_fill_v;
    logic write_fill_data_in_progress;
    logic evict_enqueued;
    logic req_busy;
  } mhu_status_s;

endpackage

`default_nettype wire

// File: mhu_miss_capture.sv
`default_nettype none

module mhu_miss_capture (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               capture_i,
  input  mhu_pkg::miss_info_s miss_i,
  output mhu_pkg::miss_ctx_s  ctx_o
);

  cache_geom_pkg::cache_addr_u line_addr;

  logic [cache_geom_pkg::WAY_WIDTH-1:0] way;
  logic                                 way_dirty;
  logic                                 way_valid;

  mhu_pkg::miss_ctx_s ctx_n;
  mhu_pkg::miss_ctx_s ctx_r;

  // miss address as seen by the tv stage
  assign line_addr.raw = miss_i.addr.raw;

  // track miss refills the way it hit on, otherwise the replacement pick
  assign way = miss_i.track_miss ? miss_i.hit_way : miss_i.chosen_way;

  // state bits of the way being replaced
  assign way_dirty = miss_i.dirty[way];
  assign way_valid = miss_i.valid[way];

  always_comb begin
    ctx_n = ctx_r;
    // line tag and set, offset is dropped
    ctx_n.tag = line_addr.fields.tag;
    ctx_n.index = line_addr.fields.index;
    ctx_n.way = way;
    // old line held in that way
    ctx_n.victim_tag = miss_i.tags[way];
    // only a live dirty line has to go back to memory
    ctx_n.victim_needs_evict = way_dirty & way_valid;
    ctx_n.track_miss = miss_i.track_miss;
    ctx_n.store_tag_miss = miss_i.store_tag_miss;
  end

  // one-cycle strobe from the pipeline, only while idle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctx_r <= '0;
    end else if (capture_i) begin
      ctx_r <= ctx_n;
    end
  end

  assign ctx_o = ctx_r;

endmodule

`default_nettype wire

// File: mhu_miss_fsm.sv
`default_nettype none

module mhu_miss_fsm (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 activate_i,
  input  mhu_pkg::miss_ctx_s   ctx_i,
  input  logic                 snoop_way_busy_i,
  input  logic                 ack_i,
  input  logic                 evict_done_i,
  input  logic                 refill_done_i,
  input  logic                 stm_fill_done_i,
  output mhu_pkg::dma_req_s    dma_req_o,
  output mhu_pkg::mhu_status_s status_o
);

  mhu_pkg::mhu_state_e state_r;
  mhu_pkg::mhu_state_e state_n;
  mhu_pkg::mhu_state_e decide_n;

  cache_geom_pkg::cache_addr_u refill_addr;
  cache_geom_pkg::cache_addr_u evict_addr;

  logic evict_victim;
  logic fill_done;

  // line-aligned addresses for the dma engine
  assign refill_addr.fields = '{tag: ctx_i.tag, index: ctx_i.index, offset: '0};
  assign evict_addr.fields = '{tag: ctx_i.victim_tag, index: ctx_i.index, offset: '0};

  // track miss refills in place, never evicts
  assign evict_victim = ctx_i.victim_needs_evict & ~ctx_i.track_miss;

  // store tag miss data comes from the store transmitter, not dma
  assign fill_done = ctx_i.store_tag_miss ? stm_fill_done_i : refill_done_i;

  // shared by the refill ack cycle and STORE_TAG_MISS
  always_comb begin
    if (!evict_victim) begin
      decide_n = mhu_pkg::WRITE_FILL_DATA;
    end else if (snoop_way_busy_i) begin
      // sbuf or tbuf still has stores for this way
      decide_n = mhu_pkg::WAIT_SNOOP_DONE;
    end else begin
      decide_n = mhu_pkg::SEND_EVICT_ADDR;
    end
  end

  always_comb begin
    state_n = state_r;
    case (state_r)
      mhu_pkg::START: begin
        if (activate_i) begin
          state_n = ctx_i.store_tag_miss ? mhu_pkg::STORE_TAG_MISS : mhu_pkg::SEND_REFILL_ADDR;
        end
      end
      // hold the request until the dma acks it
      mhu_pkg::SEND_REFILL_ADDR: begin
        if (ack_i) begin
          state_n = decide_n;
        end
      end
      // no refill, single decision cycle
      mhu_pkg::STORE_TAG_MISS: begin
        state_n = decide_n;
      end
      mhu_pkg::WAIT_SNOOP_DONE: begin
        if (!snoop_way_busy_i) begin
          state_n = mhu_pkg::SEND_EVICT_ADDR;
        end
      end
      mhu_pkg::SEND_EVICT_ADDR: begin
        if (ack_i) begin
          state_n = mhu_pkg::SEND_EVICT_DATA;
        end
      end
      // old line must leave before fill data lands
      mhu_pkg::SEND_EVICT_DATA: begin
        if (evict_done_i) begin
          state_n = mhu_pkg::WRITE_FILL_DATA;
        end
      end
      mhu_pkg::WRITE_FILL_DATA: begin
        if (fill_done) begin
          state_n = mhu_pkg::START;
        end
      end
      default: begin
        state_n = mhu_pkg::START;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= mhu_pkg::START;
    end else begin
      state_r <= state_n;
    end
  end

  // wishbone request straight from state, drops the cycle after ack
  always_comb begin
    dma_req_o = '0;
    dma_req_o.cmd = mhu_pkg::NOP;
    if (state_r == mhu_pkg::SEND_REFILL_ADDR) begin
      dma_req_o.cyc = 1'b1;
      dma_req_o.stb = 1'b1;
      dma_req_o.adr = refill_addr.raw;
      dma_req_o.cmd = mhu_pkg::REFILL_ADDR;
    end else if (state_r == mhu_pkg::SEND_EVICT_ADDR) begin
      // eviction is a write
      dma_req_o.cyc = 1'b1;
      dma_req_o.stb = 1'b1;
      dma_req_o.we = 1'b1;
      dma_req_o.adr = evict_addr.raw;
      dma_req_o.cmd = mhu_pkg::EVICT_ADDR;
    end
  end

  always_comb begin
    // pulse in the evict ack cycle
    status_o.evict_v = (state_r == mhu_pkg::SEND_EVICT_ADDR)
                     & (state_n == mhu_pkg::SEND_EVICT_DATA);
    // dirty stm fills with evict_v, clean stm fills on its decision cycle
    status_o.store_tag_miss_fill_v = ctx_i.store_tag_miss
      & (status_o.evict_v
         | ((state_r == mhu_pkg::STORE_TAG_MISS) & (state_n == mhu_pkg::WRITE_FILL_DATA)));
    status_o.write_fill_data_in_progress = (state_r == mhu_pkg::WRITE_FILL_DATA);
    // lets refill data in once the eviction is queued
    status_o.evict_enqueued = (state_r == mhu_pkg::SEND_EVICT_DATA)
                            | (state_r == mhu_pkg::WRITE_FILL_DATA);
    status_o.req_busy = (state_r == mhu_pkg::SEND_REFILL_ADDR)
                      | (state_r == mhu_pkg::STORE_TAG_MISS)
                      | (state_r == mhu_pkg::WAIT_SNOOP_DONE)
                      | (state_r == mhu_pkg::SEND_EVICT_ADDR);
  end

endmodule

`default_nettype wire

// File: mhu_top.sv
`default_nettype none

module mhu_top (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 capture_i,
  input  logic                                 activate_i,
  input  mhu_pkg::miss_info_s                  miss_i,
  input  logic                                 snoop_way_busy_i,
  input  logic                                 ack_i,
  input  logic                                 evict_done_i,
  input  logic                                 refill_done_i,
  input  logic                                 stm_fill_done_i,
  output mhu_pkg::dma_req_s                    dma_req_o,
  output mhu_pkg::mhu_status_s                 status_o,
  output logic [cache_geom_pkg::WAY_WIDTH-1:0] chosen_way_o,
  output logic                                 store_tag_miss_o,
  output logic                                 track_miss_o
);

  mhu_pkg::miss_ctx_s ctx;

  // latches the miss from the tv stage
  mhu_miss_capture u_capture (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .capture_i (capture_i),
    .miss_i    (miss_i),
    .ctx_o     (ctx)
  );

  // sequences refill, eviction and fill
  mhu_miss_fsm u_fsm (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .activate_i       (activate_i),
    .ctx_i            (ctx),
    .snoop_way_busy_i (snoop_way_busy_i),
    .ack_i            (ack_i),
    .evict_done_i     (evict_done_i),
    .refill_done_i    (refill_done_i),
    .stm_fill_done_i  (stm_fill_done_i),
    .dma_req_o        (dma_req_o),
    .status_o         (status_o)
  );

  // way and op kind for the data path
  assign chosen_way_o = ctx.way;
  assign store_tag_miss_o = ctx.store_tag_miss;
  assign track_miss_o = ctx.track_miss;

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  localparam int PERIOD = 40;
  localparam int RESET_CYCLES = 8;

  // free running clock, low at time zero
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // sync reset, released on a falling edge
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

// File: tb_mhu.sv
`default_nettype none

module tb_mhu;

  localparam int FIELDS = 18;
  localparam int MAX_CASES = 32;
  localparam int CYCLES_PER_CASE = 200;
  localparam int PERIOD = 40;
  localparam int SETTLE = 10;

  logic clk_i;
  logic reset_i;
  logic capture_i;
  logic activate_i;
  mhu_pkg::miss_info_s miss_i;
  logic snoop_way_busy_i;
  logic ack_i;
  logic evict_done_i;
  logic refill_done_i;
  logic stm_fill_done_i;
  mhu_pkg::dma_req_s dma_req_o;
  mhu_pkg::mhu_status_s status_o;
  logic [cache_geom_pkg::WAY_WIDTH-1:0] chosen_way_o;
  logic store_tag_miss_o;
  logic track_miss_o;

  // case count in word 0 and FIELDS words per case after it
  logic [31:0] case_mem [0:MAX_CASES*FIELDS];
  int num_cases;
  integer seed;
  int c;

  tb_clock_gen u_clk (.clk_o(clk_i), .reset_o(reset_i));

  mhu_top dut (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .capture_i        (capture_i),
    .activate_i       (activate_i),
    .miss_i           (miss_i),
    .snoop_way_busy_i (snoop_way_busy_i),
    .ack_i            (ack_i),
    .evict_done_i     (evict_done_i),
    .refill_done_i    (refill_done_i),
    .stm_fill_done_i  (stm_fill_done_i),
    .dma_req_o        (dma_req_o),
    .status_o         (status_o),
    .chosen_way_o     (chosen_way_o),
    .store_tag_miss_o (store_tag_miss_o),
    .track_miss_o     (track_miss_o)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Test failures found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // no request and no status while idle
  task automatic expect_idle();
    check_value("dma_req_o.cyc", dma_req_o.cyc, 32'h0);
    check_value("dma_req_o.stb", dma_req_o.stb, 32'h0);
    check_value("status_o", status_o, 32'h0);
  endtask

  task automatic run_case(input int idx);
    int base;
    int k;
    int cycle;
    int snoop_left;
    int ack_wait;
    int evict_wait;
    int fill_wait;
    int evict_delay;
    int fill_delay;
    int refill_cnt;
    int evict_cnt;
    int stm_fill_cnt;
    int acks_left;
    logic stm;
    logic exp_evict_v;
    logic exp_queued;
    logic evict_owed;
    logic evict_ack;
    logic ack_pend;
    logic ack_cycle;
    logic in_evict_data;
    logic in_fill;
    logic fill;
    logic done;
    logic held_we;
    logic [31:0] held_adr;
    base = 1 + idx * FIELDS;
    stm = case_mem[base+2][0];
    exp_evict_v = case_mem[base+15][0];
    evict_delay = $unsigned($random(seed)) % 4;
    fill_delay = $unsigned($random(seed)) % 4;
    cycle = 0;
    ack_wait = 0;
    evict_wait = 0;
    fill_wait = 0;
    refill_cnt = 0;
    evict_cnt = 0;
    stm_fill_cnt = 0;
    // address commands still owed, refill first and eviction last
    acks_left = case_mem[base+13] + exp_evict_v;
    exp_queued = 1'b0;
    evict_owed = exp_evict_v;
    ack_pend = 1'b0;
    in_evict_data = 1'b0;
    in_fill = 1'b0;
    done = 1'b0;
    held_we = 1'b0;
    held_adr = '0;
    // present the miss and strobe capture
    @(negedge clk_i);
    ack_i = 1'b0;
    evict_done_i = 1'b0;
    refill_done_i = 1'b0;
    stm_fill_done_i = 1'b0;
    miss_i.addr.raw = case_mem[base];
    miss_i.track_miss = case_mem[base+1][0];
    miss_i.store_tag_miss = stm;
    miss_i.hit_way = case_mem[base+3][cache_geom_pkg::WAY_WIDTH-1:0];
    miss_i.chosen_way = case_mem[base+4][cache_geom_pkg::WAY_WIDTH-1:0];
    for (k = 0; k < cache_geom_pkg::WAYS; k++) begin
      miss_i.tags[k] = case_mem[base+5+k][cache_geom_pkg::TAG_WIDTH-1:0];
    end
    miss_i.valid = case_mem[base+9][cache_geom_pkg::WAYS-1:0];
    miss_i.dirty = case_mem[base+10][cache_geom_pkg::WAYS-1:0];
    capture_i = 1'b1;
    #SETTLE;
    expect_idle();
    @(negedge clk_i);
    capture_i = 1'b0;
    #SETTLE;
    expect_idle();
    // context is visible one cycle after capture
    check_value("chosen_way_o", chosen_way_o, case_mem[base+17]);
    check_value("store_tag_miss_o", store_tag_miss_o, stm);
    check_value("track_miss_o", track_miss_o, case_mem[base+1]);
    @(negedge clk_i);
    activate_i = 1'b1;
    snoop_left = case_mem[base+11];
    snoop_way_busy_i = (snoop_left != 0);
    #SETTLE;
    expect_idle();
    while (!done) begin
      // responder side decided from the previous cycle
      @(negedge clk_i);
      activate_i = 1'b0;
      if (snoop_left > 0) begin
        snoop_left--;
      end
      snoop_way_busy_i = (snoop_left != 0);
      ack_i = ack_pend && (ack_wait > case_mem[base+12]);
      evict_done_i = in_evict_data && (evict_wait > evict_delay);
      fill = in_fill && (fill_wait > fill_delay);
      refill_done_i = fill && !stm;
      stm_fill_done_i = fill && stm;
      #SETTLE;
      cycle++;
      ack_cycle = dma_req_o.stb && ack_i;
      // the eviction is the last address command of a miss
      evict_ack = ack_cycle && exp_evict_v && (acks_left == 1);
      check_value("dma_req_o.cyc", dma_req_o.cyc, dma_req_o.stb);
      // busy until the last address command is acked
      check_value("status_o.req_busy", status_o.req_busy, !exp_queued);
      check_value("status_o.evict_enqueued", status_o.evict_enqueued, exp_queued);
      check_value("status_o.write_fill_data_in_progress",
                  status_o.write_fill_data_in_progress, exp_queued && !evict_owed);
      // refill goes out at once and a store tag miss never refills
      if (cycle == 1) begin
        check_value("dma_req_o.cyc", dma_req_o.cyc, !stm);
      end
      if (snoop_way_busy_i) begin
        check_value("dma_req_o.we", dma_req_o.we & dma_req_o.stb, 32'h0);
      end
      check_value("status_o.evict_v", status_o.evict_v, evict_ack);
      check_value("status_o.store_tag_miss_fill_v", status_o.store_tag_miss_fill_v,
                  stm && (evict_ack || (cycle == 1 && !exp_evict_v)));
      // request held steady while waiting for ack
      if (ack_pend) begin
        check_value("dma_req_o.adr", dma_req_o.adr, held_adr);
        check_value("dma_req_o.we", dma_req_o.we, held_we);
      end
      if (ack_cycle) begin
        check_value("dma_req_o.we", dma_req_o.we, evict_ack);
      end
      if (evict_ack) begin
        check_value("dma_req_o.adr", dma_req_o.adr, case_mem[base+16]);
        check_value("dma_req_o.cmd", dma_req_o.cmd, mhu_pkg::EVICT_ADDR);
        evict_cnt++;
      end else if (ack_cycle) begin
        check_value("dma_req_o.adr", dma_req_o.adr, case_mem[base+14]);
        check_value("dma_req_o.cmd", dma_req_o.cmd, mhu_pkg::REFILL_ADDR);
        refill_cnt++;
      end
      if (ack_cycle) begin
        acks_left--;
      end
      exp_queued = (acks_left == 0);
      if (evict_done_i) begin
        evict_owed = 1'b0;
      end
      ack_pend = dma_req_o.stb && !ack_i;
      ack_wait = ack_pend ? ack_wait + 1 : 0;
      held_adr = dma_req_o.adr;
      held_we = dma_req_o.we;
      in_evict_data = status_o.evict_enqueued && !status_o.write_fill_data_in_progress
                    && !evict_done_i;
      evict_wait = in_evict_data ? evict_wait + 1 : 0;
      stm_fill_cnt += status_o.store_tag_miss_fill_v;
      done = status_o.write_fill_data_in_progress && fill;
      in_fill = status_o.write_fill_data_in_progress && !fill;
      fill_wait = in_fill ? fill_wait + 1 : 0;
    end
    check_value("refill request count", refill_cnt, case_mem[base+13]);
    check_value("evict request count", evict_cnt, exp_evict_v);
    check_value("store_tag_miss_fill_v count", stm_fill_cnt, stm);
    $display("case %0d done after %0d cycles", idx, cycle);
  endtask

  initial begin
    seed = 32'h1490;
    capture_i = 1'b0;
    activate_i = 1'b0;
    miss_i = '0;
    snoop_way_busy_i = 1'b0;
    ack_i = 1'b0;
    evict_done_i = 1'b0;
    refill_done_i = 1'b0;
    stm_fill_done_i = 1'b0;
    $readmemh("mhu_cases.txt", case_mem);
    num_cases = case_mem[0];
    if (num_cases < 1 || num_cases > MAX_CASES) begin
      $display("mhu_cases.txt is missing or has no usable case count");
      $display("Test failures found");
      $fatal(1, "no cases to run");
    end
    // idle through reset
    do begin
      @(negedge clk_i);
      #SETTLE;
      expect_idle();
    end while (reset_i);
    for (c = 0; c < num_cases; c++) begin
      run_case(c);
    end
    $display("All tests passed!");
    $finish;
  end

  // budget scales with the number of cases
  initial begin
    @(negedge reset_i);
    #(num_cases * CYCLES_PER_CASE * PERIOD);
    $display("watchdog expired, a miss did not finish within %0d cycles per case",
             CYCLES_PER_CASE);
    $display("Test failures found");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// File: mhu_cases.txt
// first word is the case count, then one case per line, all hex:
// addr trk stm hit chs tag0 tag1 tag2 tag3 val dty snp ack rv refill ev evict way
9
12345678 0 0 0 2 00001 00002 0abcd 00004 f 0 0 0 1 12345660 0 00000000 2
800013a4 0 0 0 1 00010 15a5a 00030 00040 f 2 0 1 1 800013a0 1 0ad2d3a0 1
00000fff 0 0 1 3 00100 00200 00300 00400 7 8 0 2 1 00000fe0 0 00000000 3
deadbeef 0 0 0 0 01111 02222 03333 04444 f 1 6 0 1 deadbee0 1 00888ee0 0
40000040 1 0 3 1 0aaaa 0bbbb 0cccc 0dddd f f 0 1 1 40000040 0 00000000 3
00002020 0 1 0 2 00005 00006 00007 00008 f 0 0 0 0 00000000 0 00000000 2
76543210 0 1 0 3 00011 00022 00033 1fffff f 8 0 1 0 00000000 1 fffffa00 3
000007e0 0 1 0 0 00abc 00def 00123 00456 1 1 3 0 0 00000000 1 0055e7e0 0
00010000 1 0 2 0 12345 06789 0abcd 0ef01 f f 4 0 1 00010000 0 00000000 2

// File: verilog.f
cache_geom_pkg.sv
mhu_pkg.sv
mhu_miss_capture.sv
mhu_miss_fsm.sv
mhu_top.sv
tb_clock_gen.sv
tb_mhu.sv

// File: Bender.yml
package:
  name: mhu

sources:
  - cache_geom_pkg.sv
  - mhu_pkg.sv
  - mhu_miss_capture.sv
  - mhu_miss_fsm.sv
  - mhu_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_mhu.sv
